// ==== project.f ====
+incdir+include
hdl/mmu_pkg.sv
hdl/dtlb.sv
hdl/pte_perm_check.sv
hdl/ld_st_xlate.sv
hdl/mmu_top.sv
dv/mmu_tb.sv

// ==== Makefile ====
# Verilator build and run for the load/store MMU

SIM      := verilator
TOP      := mmu_tb
FILELIST := project.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), fails unless the run passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run passes only when the pass line shows up in the output
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/mmu_tb.sv ====
// Self-checking testbench for mmu_top; needs MMU_TLB_ENTRIES >= 4 and changes ctrl only after idle cycles
`include "mmu_settings.svh"

module mmu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned NR_ENTRIES  = `MMU_TLB_ENTRIES;
    localparam int unsigned NR_RAND     = 32;
    // directed part plus random loop with ctrl changes counted as two cycles
    localparam int unsigned NR_OPS      = 64 + 2 * NR_RAND;
    localparam int unsigned CYCLE_LIMIT = 4 * NR_OPS + 100;
    localparam logic [5:0]  LD_FAULT    = 6'd13;
    localparam logic [5:0]  ST_FAULT    = 6'd15;
    localparam logic [15:0] ASID_A      = 16'h0a11;
    localparam logic [15:0] ASID_B      = 16'h0b22;
    // pte flag bits d a g u x w r v from msb to lsb
    localparam logic [7:0]  F_D = 8'h80;
    localparam logic [7:0]  F_A = 8'h40;
    localparam logic [7:0]  F_G = 8'h20;
    localparam logic [7:0]  F_U = 8'h10;
    localparam logic [7:0]  F_X = 8'h08;
    localparam logic [7:0]  F_W = 8'h04;
    localparam logic [7:0]  F_R = 8'h02;
    localparam logic [7:0]  F_V = 8'h01;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 flush;
    mmu_pkg::xlate_ctrl_t ctrl;
    mmu_pkg::lsu_req_t    req;
    mmu_pkg::tlb_update_t upd;
    logic                 hit;
    mmu_pkg::lsu_rsp_t    rsp;
    logic                 miss;

    // reference model holding entries in write order
    mmu_pkg::tlb_update_t model_q [$];

    // expectations for the request of this cycle and their copies one cycle later
    logic                 exp_chk;
    logic                 exp_hit;
    logic                 exp_miss;
    mmu_pkg::lsu_rsp_t    exp_rsp;
    logic                 rsp_chk_q;
    logic                 exp_miss_q;
    mmu_pkg::lsu_rsp_t    exp_rsp_q;

    int unsigned          err_mismatch;
    int unsigned          err_other;

    mmu_top i_dut (
        .clk_i        ( clk_i  ),
        .rst_ni       ( rst_ni ),
        .flush_i      ( flush  ),
        .ctrl_i       ( ctrl   ),
        .lsu_req_i    ( req    ),
        .tlb_update_i ( upd    ),
        .dtlb_hit_o   ( hit    ),
        .lsu_rsp_o    ( rsp    ),
        .dtlb_miss_o  ( miss   )
    );

    initial begin : clk_gen
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    // ----------------------------------------
    // model
    // ----------------------------------------

    // tag match by the sv39 rules where superpages skip the lower vpn levels
    function automatic mmu_pkg::tlb_update_t model_lookup(logic [38:0] va, logic [15:0] asid);
        mmu_pkg::tlb_update_t found;
        found = '0;
        foreach (model_q[i]) begin
            if ((model_q[i].asid == asid || model_q[i].pte.g)
                && model_q[i].vpn[26:18] == va[38:30]
                && (model_q[i].is_1g || model_q[i].vpn[17:9] == va[29:21])
                && (model_q[i].is_1g || model_q[i].is_2m || model_q[i].vpn[8:0] == va[20:12])) begin
                found = model_q[i];
            end
        end
        return found;
    endfunction

    function automatic logic page_fault(mmu_pkg::pte_t pte, logic st, mmu_pkg::xlate_ctrl_t c);
        logic bad_priv;
        bad_priv = (c.priv == mmu_pkg::PRIV_LVL_U && !pte.u)
            || (c.priv == mmu_pkg::PRIV_LVL_S && pte.u && !c.sum);
        if (st) begin
            return bad_priv || !pte.w || !pte.d;
        end
        return bad_priv || !(pte.r || (c.mxr && pte.x));
    endfunction

    function automatic mmu_pkg::pte_t make_pte(logic [7:0] flags);
        mmu_pkg::pte_t pte;
        pte     = '0;
        pte.ppn = {12'($urandom()), $urandom()};
        {pte.d, pte.a, pte.g, pte.u, pte.x, pte.w, pte.r, pte.v} = flags;
        return pte;
    endfunction

    function automatic logic [38:0] rand_va(logic [8:0] vpn2);
        return {vpn2, 30'($urandom())};
    endfunction

    // ----------------------------------------
    // drivers that all act on the falling edge
    // ----------------------------------------

    task automatic next_cycle();
        @(negedge clk_i);
        req.valid = 1'b0;
        upd       = '0;
        flush     = 1'b0;
        exp_chk   = 1'b0;
        exp_hit   = 1'b0;
        exp_miss  = 1'b0;
        exp_rsp   = '0;
    endtask

    task automatic issue(logic [38:0] va, logic st);
        mmu_pkg::tlb_update_t ent;
        next_cycle();
        req.valid    = 1'b1;
        req.vaddr    = va;
        req.is_store = st;
        exp_chk      = 1'b1;
        ent          = model_lookup(va, ctrl.asid);
        if (!ctrl.en) begin
            // bare mode
            exp_hit       = 1'b1;
            exp_rsp.valid = 1'b1;
            exp_rsp.paddr = {17'b0, va};
        end else begin
            exp_hit       = ent.valid;
            exp_miss      = !ent.valid;
            exp_rsp.valid = ent.valid;
            if (ent.is_1g) begin
                exp_rsp.paddr = {ent.pte.ppn[43:18], va[29:0]};
            end else if (ent.is_2m) begin
                exp_rsp.paddr = {ent.pte.ppn[43:9], va[20:0]};
            end else begin
                exp_rsp.paddr = {ent.pte.ppn, va[11:0]};
            end
            if (ent.valid && page_fault(ent.pte, st, ctrl)) begin
                exp_rsp.exc.cause = st ? ST_FAULT : LD_FAULT;
                exp_rsp.exc.tval  = {{25{va[38]}}, va};
                exp_rsp.exc.valid = 1'b1;
            end
        end
    endtask

    // entry goes in under the current asid
    task automatic refill(logic [26:0] vpn, mmu_pkg::pte_t pte, logic is_2m, logic is_1g);
        next_cycle();
        upd.valid = 1'b1;
        upd.vpn   = vpn;
        upd.asid  = ctrl.asid;
        upd.pte   = pte;
        upd.is_2m = is_2m;
        upd.is_1g = is_1g;
        model_q.push_back(upd);
    endtask

    task automatic flush_tlb();
        next_cycle();
        flush = 1'b1;
        model_q.delete();
    endtask

    // idle cycle first so no response is in flight when ctrl moves
    task automatic set_ctrl(logic en, mmu_pkg::priv_lvl_e priv, logic sum, logic mxr,
                            logic [15:0] asid);
        next_cycle();
        next_cycle();
        ctrl.en   = en;
        ctrl.priv = priv;
        ctrl.sum  = sum;
        ctrl.mxr  = mxr;
        ctrl.asid = asid;
    endtask

    // ----------------------------------------
    // checking
    // ----------------------------------------

    always @(posedge clk_i or negedge rst_ni) begin : exp_stage
        if (!rst_ni) begin
            rsp_chk_q  <= 1'b0;
            exp_miss_q <= 1'b0;
            exp_rsp_q  <= '0;
        end else begin
            rsp_chk_q  <= exp_chk;
            exp_miss_q <= exp_miss;
            exp_rsp_q  <= exp_rsp;
        end
    end

    task automatic report_mismatch(string name, logic [127:0] got, logic [127:0] exp);
        err_mismatch++;
        $display("mismatch %s: got %0h expected %0h at %0t", name, got, exp, $time);
    endtask

    a_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exp_chk |-> hit == exp_hit)
        else report_mismatch("dtlb_hit_o", $sampled(hit), $sampled(exp_hit));
    a_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_chk_q |-> rsp.valid == exp_rsp_q.valid)
        else report_mismatch("lsu_rsp_o.valid", $sampled(rsp.valid), $sampled(exp_rsp_q.valid));
    a_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_chk_q |-> miss == exp_miss_q)
        else report_mismatch("dtlb_miss_o", $sampled(miss), $sampled(exp_miss_q));
    a_paddr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_chk_q && exp_rsp_q.valid |-> rsp.paddr == exp_rsp_q.paddr)
        else report_mismatch("lsu_rsp_o.paddr", $sampled(rsp.paddr), $sampled(exp_rsp_q.paddr));
    a_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_chk_q && exp_rsp_q.valid |-> rsp.exc == exp_rsp_q.exc)
        else report_mismatch("lsu_rsp_o.exc", $sampled(rsp.exc), $sampled(exp_rsp_q.exc));
    a_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !rsp_chk_q |-> !rsp.valid && !miss)
        else begin
            err_other++;
            $display("response or miss raised with no request one cycle earlier at %0t", $time);
        end

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", err_mismatch, err_other);
        if (err_mismatch + err_other == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        err_other++;
        $display("timeout, run still going after %0d cycles", CYCLE_LIMIT);
        finish_run();
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    initial begin : stimulus
        logic [38:0] va0;
        logic [38:0] va1;
        logic [38:0] va2;
        logic [38:0] va3;
        logic [38:0] va;
        int unsigned sz;
        int unsigned idx;
        void'($urandom(32'h35f2d99b));
        err_mismatch = 0;
        err_other    = 0;
        rst_ni       = 1'b0;
        flush        = 1'b0;
        ctrl         = '0;
        req          = '0;
        upd          = '0;
        exp_chk      = 1'b0;
        exp_hit      = 1'b0;
        exp_miss     = 1'b0;
        exp_rsp      = '0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // bare mode passes the address through
        for (int i = 0; i < 8; i++) begin
            issue({7'($urandom()), $urandom()}, 1'(i % 2));
        end

        // 4k page that misses and then gets a refill
        set_ctrl(1'b1, mmu_pkg::PRIV_LVL_S, 1'b0, 1'b0, ASID_A);
        va0 = rand_va(9'd1);
        issue(va0, 1'b0);
        refill(va0[38:12], make_pte(F_D | F_A | F_W | F_R | F_V), 1'b0, 1'b0);
        issue(va0, 1'b0);
        issue(va0, 1'b1);
        issue({va0[38:12], 12'($urandom())}, 1'b0);
        // 2m page with d clear where another vpn0 still hits
        // bit 38 set so the fault tval is sign-extended with ones
        va1 = rand_va(9'h102);
        refill(va1[38:12], make_pte(F_A | F_W | F_R | F_V), 1'b1, 1'b0);
        issue({va1[38:21], 21'($urandom())}, 1'b0);
        issue(va1, 1'b1);
        // 1g global user page with sum clear
        va2 = rand_va(9'd3);
        refill(va2[38:12], make_pte(F_D | F_A | F_G | F_U | F_W | F_R | F_V), 1'b0, 1'b1);
        issue({va2[38:30], 30'($urandom())}, 1'b0);
        issue(va2, 1'b1);
        // execute-only supervisor page
        va3 = rand_va(9'd4);
        refill(va3[38:12], make_pte(F_A | F_X | F_V), 1'b0, 1'b0);
        issue(va3, 1'b0);
        set_ctrl(1'b1, mmu_pkg::PRIV_LVL_S, 1'b1, 1'b1, ASID_A);
        issue(va2, 1'b0);
        issue(va2, 1'b1);
        issue(va3, 1'b0);
        // user mode
        set_ctrl(1'b1, mmu_pkg::PRIV_LVL_U, 1'b0, 1'b0, ASID_A);
        issue(va0, 1'b0);
        issue(va2, 1'b0);
        issue(va3, 1'b0);
        // under another asid only the global page survives
        set_ctrl(1'b1, mmu_pkg::PRIV_LVL_S, 1'b0, 1'b0, ASID_B);
        issue(va0, 1'b0);
        issue(va2, 1'b0);
        flush_tlb();
        issue(va0, 1'b0);
        issue(va1, 1'b0);
        issue(va2, 1'b0);

        // random entries on distinct vpn2 so no two ever overlap
        for (int k = 0; k < NR_ENTRIES; k++) begin
            sz = $urandom_range(2);
            refill({9'(16 + k), 18'($urandom())}, make_pte(8'($urandom()) | F_V),
                   sz == 1, sz == 2);
        end
        for (int n = 0; n < NR_RAND; n++) begin
            if (n % 8 == 0) begin
                set_ctrl(1'b1, (n % 16 == 0) ? mmu_pkg::PRIV_LVL_U : mmu_pkg::PRIV_LVL_S,
                         1'($urandom()), 1'($urandom()), ASID_B);
            end
            // one index past the table gives a miss
            idx = $urandom_range(NR_ENTRIES);
            va  = (idx < model_q.size()) ? {model_q[idx].vpn, 12'($urandom())}
                                         : rand_va(9'd31);
            issue(va, 1'($urandom()));
        end
        next_cycle();
        next_cycle();
        finish_run();
    end

endmodule

// ==== hdl/mmu_top.sv ====
// Load/store MMU top; no page walker inside, TLB refills arrive on tlb_update_i after a miss
module mmu_top (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  mmu_pkg::xlate_ctrl_t ctrl_i,
    input  mmu_pkg::lsu_req_t    lsu_req_i,
    input  mmu_pkg::tlb_update_t tlb_update_i,
    // cycle 0
    output logic                 dtlb_hit_o,
    // cycle 1
    output mmu_pkg::lsu_rsp_t    lsu_rsp_o,
    output logic                 dtlb_miss_o
);

    mmu_pkg::tlb_lookup_t dtlb_lu;

    // ----------------------------------------
    // data tlb
    // ----------------------------------------

    dtlb i_dtlb (
        .clk_i       ( clk_i           ),
        .rst_ni      ( rst_ni          ),
        .flush_i     ( flush_i         ),
        .update_i    ( tlb_update_i    ),
        .lu_access_i ( lsu_req_i.valid ),
        .lu_vaddr_i  ( lsu_req_i.vaddr ),
        .lu_asid_i   ( ctrl_i.asid     ),
        .lu_o        ( dtlb_lu         )
    );

    // bare mode always counts as a hit
    assign dtlb_hit_o = ctrl_i.en ? dtlb_lu.hit : 1'b1;

    // ----------------------------------------
    // translation stage
    // ----------------------------------------

    ld_st_xlate i_xlate (
        .clk_i    ( clk_i       ),
        .rst_ni   ( rst_ni      ),
        .req_i    ( lsu_req_i   ),
        .lookup_i ( dtlb_lu     ),
        .ctrl_i   ( ctrl_i      ),
        .rsp_o    ( lsu_rsp_o   ),
        .miss_o   ( dtlb_miss_o )
    );

endmodule

// ==== hdl/ld_st_xlate.sv ====
// One register stage so the response comes a cycle after the request; ctrl_i must hold until then
`include "mmu_settings.svh"

module ld_st_xlate (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  mmu_pkg::lsu_req_t     req_i,
    input  mmu_pkg::tlb_lookup_t  lookup_i,
    input  mmu_pkg::xlate_ctrl_t  ctrl_i,
    output mmu_pkg::lsu_rsp_t     rsp_o,
    output logic                  miss_o
);

    // control flops
    logic req_vld_q;
    logic hit_q;

    // payload flops
    logic [`MMU_VLEN-1:0] vaddr_q;
    logic                 is_store_q;
    mmu_pkg::pte_t        pte_q;
    logic                 is_2m_q;
    logic                 is_1g_q;

    mmu_pkg::sv39_vaddr_u va;
    logic [`MMU_PLEN-1:0] xlate_paddr;
    logic                 perm_fault;

    // ----------------------------------------
    // request stage
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            req_vld_q <= 1'b0;
            hit_q     <= 1'b0;
        end else begin
            req_vld_q <= req_i.valid;
            hit_q     <= lookup_i.hit;
        end
    end

    // request payload and lookup result
    always_ff @(posedge clk_i) begin : payload_regs
        vaddr_q    <= req_i.vaddr;
        is_store_q <= req_i.is_store;
        pte_q      <= lookup_i.pte;
        is_2m_q    <= lookup_i.is_2m;
        is_1g_q    <= lookup_i.is_1g;
    end

    // ----------------------------------------
    // physical address
    // ----------------------------------------

    assign va = vaddr_q;

    // ppn on top and the offset widens with the page size
    always_comb begin : splice
        xlate_paddr = {pte_q.ppn, va.p4k.off};
        if (is_2m_q) begin
            xlate_paddr[20:0] = va.p2m.off;
        end
        if (is_1g_q) begin
            xlate_paddr[29:0] = va.p1g.off;
        end
    end

    pte_perm_check i_perm (
        .pte_i      ( pte_q       ),
        .is_store_i ( is_store_q  ),
        .priv_i     ( ctrl_i.priv ),
        .sum_i      ( ctrl_i.sum  ),
        .mxr_i      ( ctrl_i.mxr  ),
        .fault_o    ( perm_fault  )
    );

    // ----------------------------------------
    // response
    // ----------------------------------------

    always_comb begin : response
        // bare mode passes the vaddr through
        rsp_o.valid     = req_vld_q;
        rsp_o.paddr     = {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, vaddr_q};
        rsp_o.exc.cause = mmu_pkg::EXC_NONE;
        rsp_o.exc.tval  = '0;
        rsp_o.exc.valid = 1'b0;
        miss_o          = 1'b0;

        if (ctrl_i.en) begin
            rsp_o.valid = req_vld_q && hit_q;
            rsp_o.paddr = xlate_paddr;
            // a miss keeps the response quiet until the lsu retries
            miss_o      = req_vld_q && !hit_q;
            if (req_vld_q && hit_q && perm_fault) begin
                rsp_o.exc.cause = is_store_q ? mmu_pkg::EXC_ST_PAGE_FAULT
                                             : mmu_pkg::EXC_LD_PAGE_FAULT;
                rsp_o.exc.tval  = {{(64 - `MMU_VLEN){vaddr_q[`MMU_VLEN-1]}}, vaddr_q};
                rsp_o.exc.valid = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // assertions
    // ----------------------------------------

    // the tlb only reports a hit for a valid request
    a_hit_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        hit_q |-> req_vld_q)
        else $error("ld_st_xlate: registered hit without a registered request");

    // ctrl_i feeds the permission check of the request in flight
    a_ctrl_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_vld_q |-> $stable(ctrl_i))
        else $error("ld_st_xlate: ctrl_i changed while a request was in flight");

endmodule

// ==== hdl/pte_perm_check.sv ====
// Combinational leaf permission check for loads and stores; a and v bits are not checked here
module pte_perm_check (
    input  mmu_pkg::pte_t      pte_i,
    input  logic               is_store_i,
    input  mmu_pkg::priv_lvl_e priv_i,
    input  logic               sum_i,
    input  logic               mxr_i,
    output logic               fault_o
);

    logic priv_fault;
    logic readable;
    logic ld_fault;
    logic st_fault;

    // ----------------------------------------
    // privilege
    // ----------------------------------------

    // user mode needs a user page
    // supervisor mode may touch user pages only with sum
    // machine mode never takes a privilege fault
    assign priv_fault =
        ((priv_i == mmu_pkg::PRIV_LVL_U) && !pte_i.u) ||
        ((priv_i == mmu_pkg::PRIV_LVL_S) && pte_i.u && !sum_i);

    // ----------------------------------------
    // access type
    // ----------------------------------------

    // mxr lets loads read execute-only pages
    assign readable = pte_i.r || (mxr_i && pte_i.x);

    // load side
    assign ld_fault = priv_fault || !readable;

    // store side, d clear counts as fault since
    // no hardware dirty-bit update happens here
    assign st_fault = priv_fault || !pte_i.w || !pte_i.d;

    // cause is picked by the caller from is_store
    assign fault_o = is_store_i ? st_fault : ld_fault;

endmodule

// ==== hdl/dtlb.sv ====
// Fully associative data TLB; lookup is combinational, one update per cycle, flush beats update
`include "mmu_settings.svh"

module dtlb #(
    parameter int unsigned NR_ENTRIES = `MMU_TLB_ENTRIES
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  mmu_pkg::tlb_update_t   update_i,
    input  logic                   lu_access_i,
    input  mmu_pkg::sv39_vaddr_u   lu_vaddr_i,
    input  logic [`MMU_ASID_W-1:0] lu_asid_i,
    output mmu_pkg::tlb_lookup_t   lu_o
);

    // index width, kept at 1 for a single-entry tlb
    localparam int unsigned IDX_W = (NR_ENTRIES > 1) ? $clog2(NR_ENTRIES) : 1;

    // tag per entry, vpn kept split along the sv39 levels
    typedef struct packed {
        logic [`MMU_ASID_W-1:0] asid;
        logic [8:0]             vpn2;
        logic [8:0]             vpn1;
        logic [8:0]             vpn0;
        logic                   is_2m;
        logic                   is_1g;
    } tag_t;

    logic [NR_ENTRIES-1:0] valid_q;
    tag_t                  tag_q [NR_ENTRIES];
    mmu_pkg::pte_t         pte_q [NR_ENTRIES];
    logic [IDX_W-1:0]      victim_q;

    logic [NR_ENTRIES-1:0] hit_vec;
    logic                  free_found;
    logic [IDX_W-1:0]      free_idx;
    logic [IDX_W-1:0]      wr_idx;

    // ----------------------------------------
    // lookup
    // ----------------------------------------

    // superpages ignore the lower vpn levels
    always_comb begin : tag_match
        for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
            hit_vec[i] = valid_q[i]
                && (tag_q[i].asid == lu_asid_i || pte_q[i].g)
                && (tag_q[i].vpn2 == lu_vaddr_i.p1g.vpn2)
                && (tag_q[i].is_1g || tag_q[i].vpn1 == lu_vaddr_i.p2m.vpn1)
                && (tag_q[i].is_1g || tag_q[i].is_2m
                    || tag_q[i].vpn0 == lu_vaddr_i.p4k.vpn0);
        end
    end

    // one-hot select of the matching entry
    always_comb begin : read_out
        lu_o     = '0;
        lu_o.hit = lu_access_i && (|hit_vec);
        for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                lu_o.pte   = pte_q[i];
                lu_o.is_2m = tag_q[i].is_2m;
                lu_o.is_1g = tag_q[i].is_1g;
            end
        end
    end

    // ----------------------------------------
    // replacement
    // ----------------------------------------

    // scan downwards so the lowest free slot is the one that sticks
    always_comb begin : find_free
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    // victim pointer only used once the tlb is full
    assign wr_idx = free_found ? free_idx : victim_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[wr_idx] <= 1'b1;
            // round robin, wraps at the last entry
            if (!free_found) begin
                if (victim_q == IDX_W'(NR_ENTRIES - 1)) begin
                    victim_q <= '0;
                end else begin
                    victim_q <= victim_q + 1'b1;
                end
            end
        end
    end

    // tag and pte storage
    always_ff @(posedge clk_i) begin : entry_write
        if (update_i.valid) begin
            tag_q[wr_idx].asid  <= update_i.asid;
            tag_q[wr_idx].vpn2  <= update_i.vpn[26:18];
            tag_q[wr_idx].vpn1  <= update_i.vpn[17:9];
            tag_q[wr_idx].vpn0  <= update_i.vpn[8:0];
            tag_q[wr_idx].is_2m <= update_i.is_2m;
            tag_q[wr_idx].is_1g <= update_i.is_1g;
            pte_q[wr_idx]       <= update_i.pte;
        end
    end

    // ----------------------------------------
    // assertions
    // ----------------------------------------

    // overlapping entries would make the read-out mux ambiguous
    a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lu_access_i |-> $onehot0(hit_vec))
        else $error("dtlb: more than one entry hit");

    a_upd_size: assert property (@(posedge clk_i) disable iff (!rst_ni)
        update_i.valid |-> !(update_i.is_2m && update_i.is_1g))
        else $error("dtlb: update marks both 2M and 1G page");

endmodule

// ==== hdl/mmu_pkg.sv ====
// Types for the SV39 load/store MMU; widths come from mmu_settings.svh, which must be on the include path
`include "mmu_settings.svh"

package mmu_pkg;

    // ----------------------------------------
    // privilege and exception codes
    // ----------------------------------------

    // hypervisor level 2 is not supported
    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'd0,
        PRIV_LVL_S = 2'd1,
        PRIV_LVL_M = 2'd3
    } priv_lvl_e;

    // only the two page faults can come out of this unit
    typedef enum logic [5:0] {
        EXC_NONE          = 6'd0,
        EXC_LD_PAGE_FAULT = 6'd13,
        EXC_ST_PAGE_FAULT = 6'd15
    } exc_cause_e;

    typedef struct packed {
        logic [5:0]  cause;
        // faulting vaddr, sign-extended from bit 38
        logic [63:0] tval;
        logic        valid;
    } exc_t;

    // ----------------------------------------
    // page table entry and vaddr views
    // ----------------------------------------

    // sv39 leaf entry without the reserved upper bits
    typedef struct packed {
        logic [`MMU_PPN_W-1:0] ppn;
        logic [1:0]            rsw;
        logic                  d;
        logic                  a;
        logic                  g;
        logic                  u;
        logic                  x;
        logic                  w;
        logic                  r;
        logic                  v;
    } pte_t;

    // same 39 bits, split per page size
    typedef union packed {
        struct packed {
            logic [8:0]  vpn2;
            logic [8:0]  vpn1;
            logic [8:0]  vpn0;
            logic [11:0] off;
        } p4k;
        struct packed {
            logic [8:0]  vpn2;
            logic [8:0]  vpn1;
            logic [20:0] off;
        } p2m;
        struct packed {
            logic [8:0]  vpn2;
            logic [29:0] off;
        } p1g;
    } sv39_vaddr_u;

    // ----------------------------------------
    // tlb ports
    // ----------------------------------------

    typedef struct packed {
        logic                   valid;
        logic [26:0]            vpn;
        logic [`MMU_ASID_W-1:0] asid;
        pte_t                   pte;
        logic                   is_2m;
        logic                   is_1g;
    } tlb_update_t;

    typedef struct packed {
        logic hit;
        pte_t pte;
        logic is_2m;
        logic is_1g;
    } tlb_lookup_t;

    // ----------------------------------------
    // load/store side
    // ----------------------------------------

    // translation controls, held stable while a request is in flight
    typedef struct packed {
        logic                   en;
        priv_lvl_e              priv;
        logic                   sum;
        logic                   mxr;
        logic [`MMU_ASID_W-1:0] asid;
    } xlate_ctrl_t;

    typedef struct packed {
        logic                 valid;
        logic [`MMU_VLEN-1:0] vaddr;
        logic                 is_store;
    } lsu_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`MMU_PLEN-1:0] paddr;
        exc_t                 exc;
    } lsu_rsp_t;

endpackage

// ==== include/mmu_settings.svh ====
// SV39 only: the address and page-number widths are fixed by that mode, only the TLB depth may change
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// ----------------------------------------
// address widths
// ----------------------------------------

// virtual address, three 9-bit vpn levels plus 12-bit offset
`define MMU_VLEN 39

// physical address as seen by the load/store unit
`define MMU_PLEN 56

// physical page number held in a leaf pte
`define MMU_PPN_W 44

// ----------------------------------------
// tlb sizing
// ----------------------------------------

// address space identifier carried in satp
`define MMU_ASID_W 16

// default number of data TLB entries
// any value >= 1 works, replacement is round robin once full
`define MMU_TLB_ENTRIES 4

`endif
